/* rtl/memMapPkg.sv */
package memMapPkg;

    typedef logic [31:0] dataT;
    typedef logic [31:0] addrT;
    typedef logic [7:0] ramIndexT;

    localparam int ramWords = 256;

    localparam addrT digitBase = 32'd1024;
    localparam addrT digitTop = 32'd2047;
    localparam addrT ioBase = 32'h4000_0000;

    localparam logic [5:0] offTimerHigh = 6'h00;
    localparam logic [5:0] offTimerLow = 6'h04;
    localparam logic [5:0] offTimerCtrl = 6'h08;
    localparam logic [5:0] offLed = 6'h0C;
    localparam logic [5:0] offSwitch = 6'h10;
    localparam logic [5:0] offTube = 6'h14;

    localparam int ledWidth = 8;
    localparam int tubeWidth = 18;
    localparam int timerCtrlWidth = 2;

    typedef enum logic [2:0] {
        ioNone, ioTimerHigh, ioTimerLow, ioTimerCtrl, ioLed, ioSwitch, ioTube
    } ioSelT;

    typedef enum logic [1:0] {regionRam, regionDigits, regionIo} regionT;

    localparam logic [6:0] segPatterns [10] = '{ // Segment order is gfedcba
        7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111, 7'b1100110,
        7'b1101101, 7'b1111101, 7'b0000111, 7'b1111111, 7'b1101111
    };

    typedef struct packed {
        logic write;
        regionT region;
        ramIndexT index;
        ioSelT ioSel;
        dataT wdata;
    } decodedReqT;

endpackage

/* rtl/pipeReg.sv */
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input logic clk,
    input logic reset,
    input logic inValid,
    output logic inReady,
    input payloadT inData,
    output logic outValid,
    input logic outReady,
    output payloadT outData
);

    logic full;
    payloadT data;

    assign inReady = !full || outReady; // Room when empty or the held item leaves now
    assign outValid = full;
    assign outData = data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            full <= 1'b0;
        end else if (inReady) begin
            full <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            data <= inData;
        end
    end

endmodule

/* rtl/addressDecode.sv */
`timescale 1ns/1ps

module addressDecode (
    input memMapPkg::addrT addr,
    input logic write,
    input memMapPkg::dataT wdata,
    output memMapPkg::decodedReqT decoded
);

    import memMapPkg::*;

    logic inIoPage;
    logic inDigits;

    assign inIoPage = addr[31:6] == ioBase[31:6];
    assign inDigits = (addr >= digitBase) && (addr <= digitTop);

    always_comb begin
        decoded.write = write;
        decoded.wdata = wdata;
        if (inIoPage) begin
            decoded.region = regionIo;
        end else if (inDigits) begin
            decoded.region = regionDigits;
        end else begin
            decoded.region = regionRam; // Everything else aliases into the RAM
        end
        // The table starts on a 1 KiB boundary, so bits 9 to 2 also count its entries
        decoded.index = addr[9:2];
        case (addr[5:0])
            offTimerHigh: decoded.ioSel = ioTimerHigh;
            offTimerLow: decoded.ioSel = ioTimerLow;
            offTimerCtrl: decoded.ioSel = ioTimerCtrl;
            offLed: decoded.ioSel = ioLed;
            offSwitch: decoded.ioSel = ioSwitch;
            offTube: decoded.ioSel = ioTube;
            default: decoded.ioSel = ioNone;
        endcase
        if (!inIoPage) decoded.ioSel = ioNone;
    end

endmodule

/* rtl/digitPatternRom.sv */
`timescale 1ns/1ps

module digitPatternRom (
    input memMapPkg::ramIndexT index,
    output memMapPkg::dataT pattern
);

    import memMapPkg::*;

    logic [3:0] hundreds;
    logic [3:0] tens;
    logic [3:0] units;
    logic [6:0] hundredsSeg;
    logic [6:0] tensSeg;
    logic [6:0] unitsSeg;

    // Index is at most 255, so every digit stays below ten
    assign hundreds = 4'(index / 8'd100);
    assign tens = 4'((index / 8'd10) % 8'd10);
    assign units = 4'(index % 8'd10);

    assign hundredsSeg = segPatterns[hundreds];
    assign tensSeg = segPatterns[tens];
    assign unitsSeg = segPatterns[units];

    assign pattern = dataT'({hundredsSeg, tensSeg, unitsSeg}); // Upper eleven bits are zero

endmodule

/* rtl/ioTimer.sv */
`timescale 1ns/1ps

module ioTimer (
    input logic clk,
    input logic reset,
    input logic highWrite,
    input logic ctrlWrite,
    input memMapPkg::dataT wdata,
    output memMapPkg::dataT count,
    output logic [memMapPkg::timerCtrlWidth-1:0] ctrl,
    output logic irq
);

    import memMapPkg::*;

    dataT high;
    dataT low;
    logic [timerCtrlWidth-1:0] ctrlReg;
    logic flag;

    assign count = low;
    assign ctrl = ctrlReg;
    assign irq = flag;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            high <= '0;
            low <= '0;
        end else if (highWrite) begin
            high <= wdata;
            low <= wdata; // Reload value takes effect at once
        end else if (ctrlReg[0]) begin
            low <= (low == '1) ? high : low + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrlReg <= '0;
            flag <= 1'b0;
        end else if (ctrlWrite) begin
            ctrlReg <= wdata[timerCtrlWidth-1:0];
            flag <= 1'b0; // Any control write acknowledges the interrupt
        end else if (!highWrite && ctrlReg[0] && ctrlReg[1] && low == '1) begin
            flag <= 1'b1;
        end
    end

endmodule

/* rtl/memoryAccess.sv */
`timescale 1ns/1ps

module memoryAccess (
    input logic clk,
    input logic reset,
    input logic inValid,
    output logic inReady,
    input memMapPkg::decodedReqT req,
    output logic outValid,
    input logic outReady,
    output memMapPkg::dataT rdata,
    input logic [memMapPkg::ledWidth-1:0] switches,
    output logic [memMapPkg::ledWidth-1:0] leds,
    output logic [memMapPkg::tubeWidth-1:0] tube,
    output logic timerIrq
);

    import memMapPkg::*;

    dataT ram [ramWords];
    dataT digitPattern;
    dataT timerCount;
    dataT ioData;
    logic [timerCtrlWidth-1:0] timerCtrl;
    logic consume;
    logic ioWrite;

    // The response register decides when a request may leave
    assign inReady = outReady;
    assign outValid = inValid;
    assign consume = inValid && outReady;
    assign ioWrite = consume && req.write && req.region == regionIo;

    digitPatternRom digitPatternRom_i (
        .index(req.index),
        .pattern(digitPattern)
    );

    ioTimer ioTimer_i (
        .clk(clk),
        .reset(reset),
        .highWrite(ioWrite && req.ioSel == ioTimerHigh),
        .ctrlWrite(ioWrite && req.ioSel == ioTimerCtrl),
        .wdata(req.wdata),
        .count(timerCount),
        .ctrl(timerCtrl),
        .irq(timerIrq)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < ramWords; i++) begin
                ram[i] <= '0;
            end
        end else if (consume && req.write && req.region == regionRam) begin
            ram[req.index] <= req.wdata; // Table region writes never reach here
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            leds <= '0;
            tube <= '0;
        end else if (ioWrite && req.ioSel == ioLed) begin
            leds <= req.wdata[ledWidth-1:0];
        end else if (ioWrite && req.ioSel == ioTube) begin
            tube <= req.wdata[tubeWidth-1:0];
        end
    end

    always_comb begin
        case (req.ioSel)
            ioTimerLow: ioData = timerCount;
            ioTimerCtrl: ioData = dataT'({timerIrq, timerCtrl}); // Flag sits in bit 2
            ioSwitch: ioData = dataT'(switches);
            default: ioData = '0;
        endcase
    end

    always_comb begin
        if (req.write) begin
            rdata = '0;
        end else if (req.region == regionIo) begin
            rdata = ioData;
        end else if (req.region == regionDigits) begin
            rdata = digitPattern;
        end else begin
            rdata = ram[req.index];
        end
    end

endmodule

/* rtl/dataMemoryTop.sv */
`timescale 1ns/1ps

module dataMemoryTop (
    input logic clk,
    input logic reset,
    input logic reqValid,
    output logic reqReady,
    input logic reqWrite,
    input memMapPkg::addrT reqAddr,
    input memMapPkg::dataT reqWdata,
    output logic rspValid,
    input logic rspReady,
    output memMapPkg::dataT rspData,
    input logic [memMapPkg::ledWidth-1:0] switches,
    output logic [memMapPkg::ledWidth-1:0] leds,
    output logic [memMapPkg::tubeWidth-1:0] tube,
    output logic timerIrq
);

    import memMapPkg::*;

    decodedReqT decodedReq;
    decodedReqT stagedReq;
    logic stagedValid;
    logic stagedReady;
    logic accessValid;
    logic accessReady;
    dataT accessData;

    addressDecode addressDecode_i (
        .addr(reqAddr),
        .write(reqWrite),
        .wdata(reqWdata),
        .decoded(decodedReq)
    );

    pipeReg #(.payloadT(decodedReqT)) reqStage (
        .clk(clk),
        .reset(reset),
        .inValid(reqValid),
        .inReady(reqReady),
        .inData(decodedReq),
        .outValid(stagedValid),
        .outReady(stagedReady),
        .outData(stagedReq)
    );

    memoryAccess memoryAccess_i (
        .clk(clk),
        .reset(reset),
        .inValid(stagedValid),
        .inReady(stagedReady),
        .req(stagedReq),
        .outValid(accessValid),
        .outReady(accessReady),
        .rdata(accessData),
        .switches(switches),
        .leds(leds),
        .tube(tube),
        .timerIrq(timerIrq)
    );

    pipeReg #(.payloadT(dataT)) rspStage (
        .clk(clk),
        .reset(reset),
        .inValid(accessValid),
        .inReady(accessReady),
        .inData(accessData),
        .outValid(rspValid),
        .outReady(rspReady),
        .outData(rspData)
    );

endmodule

/* testbench/dataMemory_assert.sv */
`timescale 1ns/1ps

module dataMemoryChecks (
    input logic clk,
    input logic reset,
    input logic rspValid,
    input logic rspReady,
    input logic [31:0] rspData,
    input logic timerIrq,
    input logic irqEnable
);

    assert property (@(posedge clk) disable iff (reset)
        rspValid && !rspReady |=> $stable(rspData))
        else $error("rspData changed while the response was stalled");

    assert property (@(posedge clk) $fell(reset) |-> !rspValid && !timerIrq)
        else $error("Response or interrupt active in the first cycle after reset");

    // The flag may only be set while interrupts are enabled
    assert property (@(posedge clk) disable iff (reset)
        !irqEnable && !timerIrq |=> !timerIrq)
        else $error("timerIrq rose with interrupt enable clear");

endmodule

bind dataMemoryTop dataMemoryChecks dataMemoryChecks_i (
    .*,
    .irqEnable(memoryAccess_i.timerCtrl[1])
);

/* testbench/dataMemoryTb.sv */
`timescale 1ns/1ps

module dataMemoryTb;

    typedef struct {
        logic write;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] expected;
        logic check; // Cleared where the timer makes the value unpredictable
    } stepT;

    localparam int timeoutCycles = 200;
    localparam logic [31:0] ioPage = 32'h4000_0000;
    localparam logic [6:0] segTable [10] = '{
        7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111, 7'b1100110,
        7'b1101101, 7'b1111101, 7'b0000111, 7'b1111111, 7'b1101111
    };

    logic clk;
    logic reset;
    logic reqValid;
    logic reqReady;
    logic reqWrite;
    logic [31:0] reqAddr;
    logic [31:0] reqWdata;
    logic rspValid;
    logic rspReady;
    logic [31:0] rspData;
    logic [7:0] switches;
    logic [7:0] leds;
    logic [17:0] tube;
    logic timerIrq;

    stepT steps[$];
    stepT pending[$]; // Accepted requests still waiting for their response
    logic [31:0] ramModel [256];
    logic [31:0] lastData;
    logic randomReady;
    logic timedOut;
    integer seed;
    int errorCount;
    int checkCount;
    int testErrors;
    int rspCount;
    int stallCycles;

    dataMemoryTop dataMemoryTop_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] digitWord(input int n);
        return {11'b0, segTable[n / 100], segTable[(n / 10) % 10], segTable[n % 10]};
    endfunction

    function automatic logic [31:0] modelRead(input logic [31:0] addr);
        if (addr[31:6] == ioPage[31:6]) begin
            return (addr[5:0] == 6'h10) ? {24'b0, switches} : 32'b0;
        end
        if (addr >= 32'd1024 && addr <= 32'd2047) begin
            return digitWord(int'((addr - 32'd1024) >> 2));
        end
        return ramModel[addr[9:2]];
    endfunction

    task automatic addWrite(input logic [31:0] addr, input logic [31:0] data);
        if (addr[31:6] != ioPage[31:6] && (addr < 32'd1024 || addr > 32'd2047)) begin
            ramModel[addr[9:2]] = data;
        end
        steps.push_back('{1'b1, addr, data, 32'b0, 1'b1});
    endtask

    task automatic addRead(input logic [31:0] addr);
        logic isTimer;
        isTimer = (addr == ioPage + 32'h04) || (addr == ioPage + 32'h08);
        steps.push_back('{1'b0, addr, 32'b0, modelRead(addr), !isTimer});
    endtask

    task automatic checkValue(input logic [31:0] got, input logic [31:0] want, input string what);
        checkCount++;
        assert (got === want) else begin
            errorCount++;
            $display("[FAIL] %0t: %s gave 0x%08h, expected 0x%08h", $time, what, got, want);
        end
    endtask

    task automatic reportTest(input string name);
        $display("Test %s finished with %0d errors", name, errorCount - testErrors);
        testErrors = errorCount;
    endtask

    // Drives the table and checks responses in the same cycle loop
    task automatic applyTable();
        int next;
        int idle;
        next = 0;
        idle = 0;
        while ((next < steps.size() || pending.size() != 0) && idle < timeoutCycles) begin
            reqValid <= (next < steps.size());
            if (next < steps.size()) begin
                reqWrite <= steps[next].write;
                reqAddr <= steps[next].addr;
                reqWdata <= steps[next].wdata;
            end
            rspReady <= randomReady ? 1'($random(seed)) : 1'b1;
            @(posedge clk);
            idle++;
            if (reqValid && !reqReady) begin
                stallCycles++;
            end
            if (reqValid && reqReady) begin
                pending.push_back(steps[next]);
                next++;
                idle = 0;
            end
            if (rspValid && rspReady) begin
                rspCount++;
                lastData = rspData;
                idle = 0;
                assert (pending.size() != 0) else begin
                    errorCount++;
                    $display("A response arrived at %0t with no request outstanding", $time);
                end
                if (pending.size() != 0) begin
                    if (pending[0].check) begin
                        checkValue(rspData, pending[0].expected,
                            $sformatf("access to 0x%08h", pending[0].addr));
                    end
                    void'(pending.pop_front());
                end
            end
        end
        reqValid <= 1'b0;
        rspReady <= 1'b1;
        if (idle >= timeoutCycles) begin
            timedOut = 1'b1;
            $display("Timed out after %0d idle cycles with requests or responses left", idle);
        end
        steps.delete();
    endtask

    task automatic ramTest();
        addWrite(32'h0000_0000, 32'h1111_0000);
        addWrite(32'h0000_0004, 32'h2222_0004);
        addWrite(32'h0000_03FC, 32'hCAFE_03FC);
        addWrite(32'h0000_0200, 32'h0BAD_0200);
        addWrite(32'h0000_0010, 32'h4444_0010);
        addWrite(32'h0000_1010, 32'h5555_1010); // Same word as 0x10
        addRead(32'h0000_0000);
        addRead(32'h0000_0004);
        addRead(32'h0000_03FC);
        addRead(32'h0000_0200);
        addRead(32'h0000_0010);
        addRead(32'h0000_1010);
        addRead(32'h0000_0800);
        applyTable();
        reportTest("ram");
    endtask

    task automatic digitTest();
        logic [7:0] idx;
        addRead(32'd1024);
        addRead(32'd2044);
        for (int i = 0; i < 20; i++) begin
            idx = 8'($random(seed));
            addRead(32'd1024 + {22'b0, idx, 2'b00});
        end
        addWrite(32'd1172, 32'hDEAD_BEEF);
        addRead(32'd1172);
        addRead(32'd148); // RAM word sharing bits 9-2 with entry 37
        applyTable();
        reportTest("digits");
    endtask

    task automatic ioTest();
        addWrite(ioPage + 32'h0C, 32'h0000_00A5);
        addWrite(ioPage + 32'h14, 32'hFFF2_3456);
        addRead(ioPage + 32'h10);
        addRead(ioPage + 32'h0C);
        addWrite(ioPage + 32'h18, 32'hFFFF_FFFF);
        addRead(ioPage + 32'h18);
        addRead(ioPage + 32'h1C);
        addRead(ioPage + 32'h20);
        addRead(ioPage + 32'h3C);
        applyTable();
        checkValue({24'b0, leds}, 32'h0000_00A5, "leds");
        checkValue({14'b0, tube}, 32'hFFF2_3456 & 32'h0003_FFFF, "tube");
        reportTest("io");
    endtask

    task automatic streamTest();
        logic [31:0] kind;
        logic [31:0] addr;
        int startCount;
        int startStalls;
        for (int i = 0; i < 40; i++) begin
            kind = $random(seed);
            addr = {19'b0, kind[6], 6'b0, kind[5:2], 2'b00}; // Bit 12 picks the alias
            case (kind[1:0])
                2'd0, 2'd1: addWrite(addr, $random(seed));
                2'd2: addRead(addr);
                default: addRead(32'd1024 + {22'b0, kind[15:8], 2'b00});
            endcase
        end
        startCount = rspCount;
        startStalls = stallCycles;
        randomReady = 1'b1;
        applyTable();
        randomReady = 1'b0;
        checkValue(32'(rspCount - startCount), 32'd40, "response count");
        checkCount++;
        assert (stallCycles > startStalls) else begin
            errorCount++;
            $display("reqReady never fell while responses were blocked");
        end
        reportTest("backpressure");
    endtask

    task automatic timerTest();
        int waited;
        addWrite(ioPage + 32'h00, 32'hFFFF_FFF0);
        addWrite(ioPage + 32'h08, 32'd3);
        applyTable();
        waited = 0;
        while (!timerIrq && waited < timeoutCycles) begin
            @(posedge clk);
            waited++;
        end
        if (!timerIrq) begin
            timedOut = 1'b1;
            $display("Timed out waiting for the timer interrupt");
            return;
        end
        addRead(ioPage + 32'h08);
        applyTable();
        checkValue(lastData & 32'h7, 32'h7, "timer control");
        addRead(ioPage + 32'h04);
        applyTable();
        checkCount++;
        assert (lastData >= 32'hFFFF_FFF0) else begin
            errorCount++;
            $display("[FAIL] %0t: timer count 0x%08h is below the reload value", $time, lastData);
        end
        addWrite(ioPage + 32'h08, 32'd1); // Keeps counting with interrupts off
        applyTable();
        checkValue({31'b0, timerIrq}, 32'd0, "timerIrq after control write");
        addWrite(ioPage + 32'h08, 32'd0);
        applyTable();
        reportTest("timer");
    endtask

    initial begin
        seed = 15853;
        reset = 1'b1;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddr = '0;
        reqWdata = '0;
        rspReady = 1'b1;
        switches = 8'h5A;
        randomReady = 1'b0;
        timedOut = 1'b0;
        foreach (ramModel[i]) begin
            ramModel[i] = '0;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        ramTest();
        if (!timedOut) digitTest();
        if (!timedOut) ioTest();
        if (!timedOut) streamTest();
        if (!timedOut) timerTest();
        $display("Summary: %0d checks, %0d failed", checkCount, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* list.f */
rtl/memMapPkg.sv
rtl/pipeReg.sv
rtl/addressDecode.sv
rtl/digitPatternRom.sv
rtl/ioTimer.sv
rtl/memoryAccess.sv
rtl/dataMemoryTop.sv
testbench/dataMemory_assert.sv
testbench/dataMemoryTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
    --top-module dataMemoryTb -o dataMemorySim

output=$(./obj_dir/dataMemorySim || true)
echo "$output"

if grep -qF "** PASS **" <<< "$output"; then
    exit 0
fi
exit 1
